/* build.f */
hw/simplebus_pkg.sv
hw/periph_map_pkg.sv
hw/simplebus_master.sv
hw/simplebus_interconnect.sv
hw/register_bank.sv
hw/mailbox_fifo.sv
hw/simplebus_subsystem.sv
verification/simplebus_subsystem_tb.sv

/* run.sh */
#!/bin/sh
# Compile the subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f build.f \
        --top-module simplebus_subsystem_tb -o simplebus_subsystem_sim; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/simplebus_subsystem_sim)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

/* verification/simplebus_subsystem_tb.sv */
// Subsystem random command testbench
`timescale 1ns/1ps
`default_nettype none

module simplebus_subsystem_tb;

    localparam int fifo_depth = 8;
    localparam int timeout_cycles = 50;
    // Inputs change this many ns after each rising edge
    localparam int drive_delay = 2;

    logic clock = 1'b0;
    logic rst_n;
    logic cmd_write;
    logic cmd_read;
    logic [simplebus_pkg::addr_width-1:0] cmd_address;
    logic [simplebus_pkg::data_width-1:0] cmd_write_data;
    logic busy;
    logic done;
    logic [simplebus_pkg::data_width-1:0] rsp_read_data;

    // Reference state of both peripherals
    logic [31:0] model_regs [16];
    logic [31:0] model_fifo [$];
    logic model_overflow;

    int error_count = 0;
    int check_count = 0;
    int failed_tests = 0;
    int test_errors_start = 0;

    simplebus_subsystem #(
        .fifo_depth(fifo_depth)
    ) u_simplebus_subsystem (
        .clock(clock),
        .rst_n(rst_n),
        .cmd_write(cmd_write),
        .cmd_read(cmd_read),
        .cmd_address(cmd_address),
        .cmd_write_data(cmd_write_data),
        .busy(busy),
        .done(done),
        .rsp_read_data(rsp_read_data)
    );

    always #20 clock = ~clock;

    function automatic logic in_regbank(input logic [31:0] address);
        return (address >= periph_map_pkg::regbank_low) && (address < periph_map_pkg::regbank_high);
    endfunction

    function automatic logic in_mailbox(input logic [31:0] address);
        return (address >= periph_map_pkg::mailbox_low) && (address < periph_map_pkg::mailbox_high);
    endfunction

    // Count in the low bits, then full, empty and sticky overflow
    function automatic logic [31:0] status_expected();
        logic [31:0] word;
        word = '0;
        word[15:0] = 16'(model_fifo.size());
        word[periph_map_pkg::status_full_bit] = (model_fifo.size() == fifo_depth);
        word[periph_map_pkg::status_empty_bit] = (model_fifo.size() == 0);
        word[periph_map_pkg::status_overflow_bit] = model_overflow;
        return word;
    endfunction

    function automatic void model_write(input logic [31:0] address, input logic [31:0] data);
        logic [31:0] offset;
        if (in_regbank(address)) begin
            offset = address - periph_map_pkg::regbank_low;
            model_regs[offset[5:2]] = data;
        end else if (in_mailbox(address)) begin
            offset = address - periph_map_pkg::mailbox_low;
            // Status writes and unused offsets have no effect
            if (offset == 32'(periph_map_pkg::mailbox_data_offset)) begin
                if (model_fifo.size() < fifo_depth) begin
                    model_fifo.push_back(data);
                end else begin
                    model_overflow = 1'b1;
                end
            end
        end
    endfunction

    // Addresses outside both windows read as zero
    function automatic logic [31:0] model_read(input logic [31:0] address);
        logic [31:0] offset;
        logic [31:0] value;
        value = '0;
        if (in_regbank(address)) begin
            offset = address - periph_map_pkg::regbank_low;
            value = model_regs[offset[5:2]];
        end else if (in_mailbox(address)) begin
            offset = address - periph_map_pkg::mailbox_low;
            if (offset == 32'(periph_map_pkg::mailbox_data_offset)) begin
                if (model_fifo.size() != 0) begin
                    value = model_fifo.pop_front();
                end
            end else if (offset == 32'(periph_map_pkg::mailbox_status_offset)) begin
                value = status_expected();
                model_overflow = 1'b0;
            end
        end
        return value;
    endfunction

    function automatic logic [31:0] regbank_address();
        return periph_map_pkg::regbank_low + {26'd0, 4'($urandom % 16), 2'b00};
    endfunction

    // Word aligned addresses in the gaps around and above the two windows
    function automatic logic [31:0] outside_address();
        logic [31:0] pick;
        pick = $urandom % 3;
        if (pick == 0) begin
            return periph_map_pkg::regbank_high + {20'd0, 10'($urandom % 960), 2'b00};
        end else if (pick == 1) begin
            return periph_map_pkg::mailbox_high + {18'd0, 12'($urandom % 4096), 2'b00};
        end
        return ($urandom | 32'h8000_0000) & 32'hffff_fffc;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        assert (actual === expected) else begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic wait_not_busy(output logic ok);
        int waited;
        waited = 0;
        while (busy && waited < timeout_cycles) begin
            @(posedge clock);
            #drive_delay;
            waited++;
        end
        ok = !busy;
        if (!ok) begin
            $display("Timed out waiting for busy to fall before a command");
            error_count++;
        end
    endtask

    task automatic wait_done(input logic [31:0] address, output logic ok);
        int waited;
        waited = 0;
        while (!done && waited < timeout_cycles) begin
            @(posedge clock);
            #drive_delay;
            waited++;
        end
        ok = done;
        if (!ok) begin
            $display("Timed out waiting for done after a command to address %h", address);
            error_count++;
        end
    endtask

    // Runs one host command from the strobe to the done pulse
    task automatic run_command(input logic write, input logic [31:0] address,
                               input logic [31:0] data, output logic [31:0] read_data);
        logic ok;
        read_data = '0;
        wait_not_busy(ok);
        if (ok) begin
            cmd_write = write;
            cmd_read = !write;
            cmd_address = address;
            cmd_write_data = data;
            @(posedge clock);
            #drive_delay;
            cmd_write = 1'b0;
            cmd_read = 1'b0;
            wait_done(address, ok);
            read_data = rsp_read_data;
        end
    endtask

    task automatic write_word(input logic [31:0] address, input logic [31:0] data);
        logic [31:0] unused_data;
        model_write(address, data);
        run_command(1'b1, address, data, unused_data);
    endtask

    task automatic read_and_check(input logic [31:0] address, output logic [31:0] value);
        logic [31:0] expected;
        expected = model_read(address);
        run_command(1'b0, address, '0, value);
        check_value($sformatf("rsp_read_data from %h", address), value, expected);
    endtask

    task automatic finish_test(input string name);
        if (error_count == test_errors_start) begin
            $display("Test %s passed", name);
        end else begin
            $display("Test %s failed with %0d errors", name, error_count - test_errors_start);
            failed_tests++;
        end
        test_errors_start = error_count;
    endtask

    // A write strobe raised during an accepted write must leave no trace
    task automatic ignored_strobe_test();
        logic [31:0] first_address;
        logic [31:0] second_address;
        logic [31:0] first_data;
        logic [31:0] value;
        logic ok;
        int done_pulses;
        first_address = periph_map_pkg::regbank_low + 32'h8;
        second_address = periph_map_pkg::regbank_low + 32'h14;
        first_data = $urandom;
        done_pulses = 0;
        wait_not_busy(ok);
        model_write(first_address, first_data);
        cmd_write = 1'b1;
        cmd_address = first_address;
        cmd_write_data = first_data;
        @(posedge clock);
        #drive_delay;
        cmd_write = 1'b0;
        check_value("busy", 32'(busy), 32'd1);
        @(posedge clock);
        #drive_delay;
        cmd_write = 1'b1;
        cmd_address = second_address;
        cmd_write_data = ~first_data;
        @(posedge clock);
        #drive_delay;
        cmd_write = 1'b0;
        // Watch long enough for a second transaction to have finished too
        for (int i = 0; i < 20; i++) begin
            if (done) begin
                done_pulses++;
            end
            @(posedge clock);
            #drive_delay;
        end
        check_value("done pulse count", 32'(done_pulses), 32'd1);
        check_value("busy", 32'(busy), 32'd0);
        read_and_check(first_address, value);
        read_and_check(second_address, value);
    endtask

    initial begin
        logic [31:0] got;
        logic [31:0] data_address;
        logic [31:0] status_address;
        int choice;
        void'($urandom(32'h354b36ea));
        data_address = periph_map_pkg::mailbox_low + 32'(periph_map_pkg::mailbox_data_offset);
        status_address = periph_map_pkg::mailbox_low + 32'(periph_map_pkg::mailbox_status_offset);
        rst_n = 1'b0;
        cmd_write = 1'b0;
        cmd_read = 1'b0;
        cmd_address = '0;
        cmd_write_data = '0;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
        model_overflow = 1'b0;
        repeat (16) @(posedge clock);
        #drive_delay;
        rst_n = 1'b1;
        @(posedge clock);
        #drive_delay;

        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);
        for (int i = 0; i < 16; i++) begin
            read_and_check(periph_map_pkg::regbank_low + 32'(i * 4), got);
        end
        read_and_check(status_address, got);
        finish_test("reset state");

        for (int i = 0; i < 200; i++) begin
            if ($urandom % 2 == 0) begin
                write_word(regbank_address(), $urandom);
            end else begin
                read_and_check(regbank_address(), got);
            end
        end
        finish_test("register bank random access");

        // Pushes and pops equally likely so the FIFO wanders between its limits
        for (int i = 0; i < 150; i++) begin
            choice = $urandom % 8;
            if (choice < 3) begin
                write_word(data_address, $urandom);
            end else if (choice < 6) begin
                read_and_check(data_address, got);
            end else begin
                read_and_check(status_address, got);
            end
        end
        while (model_fifo.size() != 0) begin
            read_and_check(data_address, got);
        end
        read_and_check(data_address, got);
        read_and_check(status_address, got);
        finish_test("mailbox push pop and status");

        for (int i = 0; i < fifo_depth + 2; i++) begin
            write_word(data_address, $urandom);
        end
        read_and_check(status_address, got);
        check_value("rsp_read_data overflow bit",
                    32'(got[periph_map_pkg::status_overflow_bit]), 32'd1);
        read_and_check(status_address, got);
        check_value("rsp_read_data overflow bit",
                    32'(got[periph_map_pkg::status_overflow_bit]), 32'd0);
        for (int i = 0; i < fifo_depth; i++) begin
            read_and_check(data_address, got);
        end
        finish_test("mailbox overflow");

        write_word(data_address, $urandom);
        write_word(data_address, $urandom);
        for (int i = 0; i < 40; i++) begin
            if ($urandom % 2 == 0) begin
                write_word(outside_address(), $urandom);
            end else begin
                read_and_check(outside_address(), got);
            end
        end
        for (int i = 0; i < 16; i++) begin
            read_and_check(periph_map_pkg::regbank_low + 32'(i * 4), got);
        end
        read_and_check(status_address, got);
        while (model_fifo.size() != 0) begin
            read_and_check(data_address, got);
        end
        finish_test("unmapped addresses");

        ignored_strobe_test();
        finish_test("strobe while busy");

        $display("Tests run: 6, failed: %0d, checks: %0d, errors: %0d",
                 failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/simplebus_subsystem.sv */
// Peripheral subsystem top level
`timescale 1ns/1ps
`default_nettype none

module simplebus_subsystem #(
    parameter logic [simplebus_pkg::addr_width-1:0] regbank_low = periph_map_pkg::regbank_low,
    parameter logic [simplebus_pkg::addr_width-1:0] regbank_high = periph_map_pkg::regbank_high,
    parameter logic [simplebus_pkg::addr_width-1:0] mailbox_low = periph_map_pkg::mailbox_low,
    parameter logic [simplebus_pkg::addr_width-1:0] mailbox_high = periph_map_pkg::mailbox_high,
    parameter int unsigned fifo_depth = 8
) (
    input wire logic clock,
    input wire logic rst_n,
    input wire logic cmd_write,
    input wire logic cmd_read,
    input wire logic [simplebus_pkg::addr_width-1:0] cmd_address,
    input wire logic [simplebus_pkg::data_width-1:0] cmd_write_data,
    output logic busy,
    output logic done,
    output logic [simplebus_pkg::data_width-1:0] rsp_read_data
);

    // Master side of the interconnect
    logic [simplebus_pkg::addr_width-1:0] m_address;
    logic [simplebus_pkg::data_width-1:0] m_write_data;
    logic m_write_strobe;
    logic m_read_strobe;
    logic [simplebus_pkg::data_width-1:0] m_read_data;
    logic m_ready;

    // Register bank link
    logic [simplebus_pkg::addr_width-1:0] s1_address;
    logic [simplebus_pkg::data_width-1:0] s1_write_data;
    logic s1_write_strobe;
    logic s1_read_strobe;
    logic [simplebus_pkg::data_width-1:0] s1_read_data;
    logic s1_ready;

    // Mailbox link
    logic [simplebus_pkg::addr_width-1:0] s2_address;
    logic [simplebus_pkg::data_width-1:0] s2_write_data;
    logic s2_write_strobe;
    logic s2_read_strobe;
    logic [simplebus_pkg::data_width-1:0] s2_read_data;
    logic s2_ready;

    simplebus_master u_master (
        .clock(clock),
        .rst_n(rst_n),
        .cmd_write(cmd_write),
        .cmd_read(cmd_read),
        .cmd_address(cmd_address),
        .cmd_write_data(cmd_write_data),
        .sb_read_data(m_read_data),
        .sb_ready(m_ready),
        .busy(busy),
        .done(done),
        .rsp_read_data(rsp_read_data),
        .sb_address(m_address),
        .sb_write_data(m_write_data),
        .sb_write_strobe(m_write_strobe),
        .sb_read_strobe(m_read_strobe)
    );

    // Slave one is the register bank, slave two the mailbox
    simplebus_interconnect #(
        .slave_1_low(regbank_low),
        .slave_1_high(regbank_high),
        .slave_2_low(mailbox_low),
        .slave_2_high(mailbox_high)
    ) u_interconnect (
        .clock(clock),
        .rst_n(rst_n),
        .m_address(m_address),
        .m_write_data(m_write_data),
        .m_write_strobe(m_write_strobe),
        .m_read_strobe(m_read_strobe),
        .s1_read_data(s1_read_data),
        .s1_ready(s1_ready),
        .s2_read_data(s2_read_data),
        .s2_ready(s2_ready),
        .m_read_data(m_read_data),
        .m_ready(m_ready),
        .s1_address(s1_address),
        .s1_write_data(s1_write_data),
        .s1_write_strobe(s1_write_strobe),
        .s1_read_strobe(s1_read_strobe),
        .s2_address(s2_address),
        .s2_write_data(s2_write_data),
        .s2_write_strobe(s2_write_strobe),
        .s2_read_strobe(s2_read_strobe)
    );

    register_bank u_register_bank (
        .clock(clock),
        .rst_n(rst_n),
        .sb_address(s1_address),
        .sb_write_data(s1_write_data),
        .sb_write_strobe(s1_write_strobe),
        .sb_read_strobe(s1_read_strobe),
        .sb_read_data(s1_read_data),
        .sb_ready(s1_ready)
    );

    mailbox_fifo #(
        .fifo_depth(fifo_depth)
    ) u_mailbox_fifo (
        .clock(clock),
        .rst_n(rst_n),
        .sb_address(s2_address),
        .sb_write_data(s2_write_data),
        .sb_write_strobe(s2_write_strobe),
        .sb_read_strobe(s2_read_strobe),
        .sb_read_data(s2_read_data),
        .sb_ready(s2_ready)
    );

endmodule

`default_nettype wire

/* hw/mailbox_fifo.sv */
// FIFO mailbox peripheral
`timescale 1ns/1ps
`default_nettype none

module mailbox_fifo #(
    parameter int unsigned fifo_depth = 8
) (
    input wire logic clock,
    input wire logic rst_n,
    input wire logic [simplebus_pkg::addr_width-1:0] sb_address,
    input wire logic [simplebus_pkg::data_width-1:0] sb_write_data,
    input wire logic sb_write_strobe,
    input wire logic sb_read_strobe,
    output logic [simplebus_pkg::data_width-1:0] sb_read_data,
    output logic sb_ready
);

    localparam int unsigned ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int unsigned count_width = $clog2(fifo_depth + 1);

    logic [simplebus_pkg::data_width-1:0] entries [fifo_depth];
    logic [ptr_width-1:0] write_ptr;
    logic [ptr_width-1:0] read_ptr;
    logic [count_width-1:0] count;
    logic overflow;
    logic full;
    logic empty;
    logic [3:0] offset;
    logic data_access;
    logic status_access;
    logic push;
    logic pop;
    logic [simplebus_pkg::data_width-1:0] status_word;

    // Pointers wrap at the depth, which need not be a power of two
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(fifo_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Byte offset of the access inside the mailbox window
    assign offset = sb_address[3:0];
    assign data_access = (offset == 4'(periph_map_pkg::mailbox_data_offset));
    assign status_access = (offset == 4'(periph_map_pkg::mailbox_status_offset));

    assign full = (count == count_width'(fifo_depth));
    assign empty = (count == '0);
    assign push = sb_write_strobe && data_access && !full;
    assign pop = sb_read_strobe && data_access && !empty;

    assign sb_ready = !(sb_write_strobe || sb_read_strobe);

    // Count in the low bits, flags at their fixed positions above it
    always_comb begin
        status_word = '0;
        status_word[count_width-1:0] = count;
        status_word[periph_map_pkg::status_full_bit] = full;
        status_word[periph_map_pkg::status_empty_bit] = empty;
        status_word[periph_map_pkg::status_overflow_bit] = overflow;
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entries[write_ptr] <= sb_write_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            write_ptr <= '0;
            read_ptr <= '0;
            count <= '0;
            overflow <= 1'b0;
            sb_read_data <= '0;
        end else begin
            if (push) begin
                write_ptr <= next_ptr(write_ptr);
            end
            if (pop) begin
                read_ptr <= next_ptr(read_ptr);
            end
            // Only one transaction is ever in flight, so push and pop never meet
            if (push) begin
                count <= count + 1'b1;
            end else if (pop) begin
                count <= count - 1'b1;
            end
            // Sticky until software has seen it in a status read
            if (sb_write_strobe && data_access && full) begin
                overflow <= 1'b1;
            end else if (sb_read_strobe && status_access) begin
                overflow <= 1'b0;
            end
            // A pop from an empty FIFO and reads of unused offsets return zero
            if (pop) begin
                sb_read_data <= entries[read_ptr];
            end else if (sb_read_strobe && status_access) begin
                sb_read_data <= status_word;
            end else begin
                sb_read_data <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/register_bank.sv */
// General purpose register bank
`timescale 1ns/1ps
`default_nettype none

module register_bank (
    input wire logic clock,
    input wire logic rst_n,
    input wire logic [simplebus_pkg::addr_width-1:0] sb_address,
    input wire logic [simplebus_pkg::data_width-1:0] sb_write_data,
    input wire logic sb_write_strobe,
    input wire logic sb_read_strobe,
    output logic [simplebus_pkg::data_width-1:0] sb_read_data,
    output logic sb_ready
);

    localparam int unsigned word_count = 16;

    logic [simplebus_pkg::data_width-1:0] words [word_count];
    logic [3:0] word_index;

    // Word addressed, the two low address bits select a byte and are dropped
    assign word_index = sb_address[5:2];

    // Ready drops only in the strobe cycle and is back with the read data
    assign sb_ready = !(sb_write_strobe || sb_read_strobe);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < word_count; i++) begin
                words[i] <= '0;
            end
            sb_read_data <= '0;
        end else begin
            if (sb_write_strobe) begin
                words[word_index] <= sb_write_data;
            end
            // Data is held for one cycle only so the interconnect can OR it
            sb_read_data <= sb_read_strobe ? words[word_index] : '0;
        end
    end

endmodule

`default_nettype wire

/* hw/simplebus_interconnect.sv */
// Simple bus interconnect, one master and two slaves
`timescale 1ns/1ps
`default_nettype none

module simplebus_interconnect #(
    parameter logic [simplebus_pkg::addr_width-1:0] slave_1_low = '0,
    parameter logic [simplebus_pkg::addr_width-1:0] slave_1_high = '1,
    parameter logic [simplebus_pkg::addr_width-1:0] slave_2_low = '0,
    parameter logic [simplebus_pkg::addr_width-1:0] slave_2_high = '1
) (
    input wire logic clock,
    input wire logic rst_n,
    input wire logic [simplebus_pkg::addr_width-1:0] m_address,
    input wire logic [simplebus_pkg::data_width-1:0] m_write_data,
    input wire logic m_write_strobe,
    input wire logic m_read_strobe,
    input wire logic [simplebus_pkg::data_width-1:0] s1_read_data,
    input wire logic s1_ready,
    input wire logic [simplebus_pkg::data_width-1:0] s2_read_data,
    input wire logic s2_ready,
    output logic [simplebus_pkg::data_width-1:0] m_read_data,
    output logic m_ready,
    output logic [simplebus_pkg::addr_width-1:0] s1_address,
    output logic [simplebus_pkg::data_width-1:0] s1_write_data,
    output logic s1_write_strobe,
    output logic s1_read_strobe,
    output logic [simplebus_pkg::addr_width-1:0] s2_address,
    output logic [simplebus_pkg::data_width-1:0] s2_write_data,
    output logic s2_write_strobe,
    output logic s2_read_strobe
);

    logic s1_hit;
    logic s2_hit;

    // Half-open windows, lower bound included and upper bound excluded
    assign s1_hit = (m_address >= slave_1_low) && (m_address < slave_1_high);
    assign s2_hit = (m_address >= slave_2_low) && (m_address < slave_2_high);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            s1_address <= '0;
            s1_write_data <= '0;
            s1_write_strobe <= 1'b0;
            s1_read_strobe <= 1'b0;
            s2_address <= '0;
            s2_write_data <= '0;
            s2_write_strobe <= 1'b0;
            s2_read_strobe <= 1'b0;
            m_read_data <= '0;
            m_ready <= 1'b1;
        end else begin
            // An unselected slave sees an idle all-zero bus
            s1_address <= s1_hit ? m_address : '0;
            s1_write_data <= s1_hit ? m_write_data : '0;
            s1_write_strobe <= s1_hit && m_write_strobe;
            s1_read_strobe <= s1_hit && m_read_strobe;
            s2_address <= s2_hit ? m_address : '0;
            s2_write_data <= s2_hit ? m_write_data : '0;
            s2_write_strobe <= s2_hit && m_write_strobe;
            s2_read_strobe <= s2_hit && m_read_strobe;
            // Idle slaves drive zero data and high ready, so OR and AND
            // merge the two responses without a select
            m_read_data <= s1_read_data | s2_read_data;
            m_ready <= s1_ready && s2_ready;
        end
    end

endmodule

`default_nettype wire

/* hw/simplebus_master.sv */
// Simple bus master
`timescale 1ns/1ps
`default_nettype none

module simplebus_master (
    input wire logic clock,
    input wire logic rst_n,
    input wire logic cmd_write,
    input wire logic cmd_read,
    input wire logic [simplebus_pkg::addr_width-1:0] cmd_address,
    input wire logic [simplebus_pkg::data_width-1:0] cmd_write_data,
    input wire logic [simplebus_pkg::data_width-1:0] sb_read_data,
    input wire logic sb_ready,
    output logic busy,
    output logic done,
    output logic [simplebus_pkg::data_width-1:0] rsp_read_data,
    output logic [simplebus_pkg::addr_width-1:0] sb_address,
    output logic [simplebus_pkg::data_width-1:0] sb_write_data,
    output logic sb_write_strobe,
    output logic sb_read_strobe
);

    // FSM encoding
    localparam logic [1:0] state_idle = 2'd0;
    localparam logic [1:0] state_issue = 2'd1;
    localparam logic [1:0] state_wait = 2'd2;

    localparam int unsigned delay_width = $clog2(simplebus_pkg::response_delay + 1);

    logic [1:0] state;
    logic [delay_width-1:0] delay_count;

    // The host may only start a command while the FSM sits in idle
    assign busy = (state != state_idle);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= state_idle;
            delay_count <= '0;
            done <= 1'b0;
            rsp_read_data <= '0;
            sb_address <= '0;
            sb_write_data <= '0;
            sb_write_strobe <= 1'b0;
            sb_read_strobe <= 1'b0;
        end else begin
            // Done is a single-cycle pulse unless set again below
            done <= 1'b0;
            case (state)
                state_idle: begin
                    if (cmd_write || cmd_read) begin
                        // Latch the command, the strobe goes out next cycle
                        sb_address <= cmd_address;
                        sb_write_data <= cmd_write_data;
                        sb_write_strobe <= cmd_write;
                        // A write wins if the host raises both strobes
                        sb_read_strobe <= cmd_read && !cmd_write;
                        state <= state_issue;
                    end
                end
                state_issue: begin
                    // Strobe has been on the bus for one cycle, drop it and
                    // keep address and data steady until the response
                    sb_write_strobe <= 1'b0;
                    sb_read_strobe <= 1'b0;
                    delay_count <= delay_width'(simplebus_pkg::response_delay);
                    state <= state_wait;
                end
                state_wait: begin
                    // Ready is still stale while the request travels through
                    // the interconnect, so it is ignored until the count ends
                    if (delay_count != '0) begin
                        delay_count <= delay_count - 1'b1;
                    end else if (sb_ready) begin
                        rsp_read_data <= sb_read_data;
                        done <= 1'b1;
                        state <= state_idle;
                    end
                end
                default: begin
                    state <= state_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/periph_map_pkg.sv */
// Peripheral address map
`default_nettype none

package periph_map_pkg;

    // Register bank window, sixteen words, upper bound exclusive
    localparam logic [simplebus_pkg::addr_width-1:0] regbank_low = 32'h0000_0000;
    localparam logic [simplebus_pkg::addr_width-1:0] regbank_high = 32'h0000_0040;

    // Mailbox window, four words, upper bound exclusive
    localparam logic [simplebus_pkg::addr_width-1:0] mailbox_low = 32'h0000_1000;
    localparam logic [simplebus_pkg::addr_width-1:0] mailbox_high = 32'h0000_1010;

    // Byte offsets of the mailbox registers inside its window
    localparam int unsigned mailbox_data_offset = 0;
    localparam int unsigned mailbox_status_offset = 4;

    // Mailbox status word layout
    // The occupancy count sits in the low bits below these flags
    localparam int unsigned status_full_bit = 16;
    localparam int unsigned status_empty_bit = 17;
    localparam int unsigned status_overflow_bit = 18;

endpackage

`default_nettype wire

/* hw/simplebus_pkg.sv */
// Simple bus common definitions
`default_nettype none

package simplebus_pkg;

    // Width of the byte address carried on sb_address
    localparam int unsigned addr_width = 32;

    // Width of both read and write data words
    localparam int unsigned data_width = 32;

    // Cycles of round-trip latency through the registered interconnect
    // The request takes one cycle to reach a slave and the response one more
    // cycle to come back, so ready seen by the master during this window
    // still reflects the previous transaction
    localparam int unsigned response_delay = 2;

endpackage

`default_nettype wire
